/* Makefile */
TOP := usb_tx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/usb_tx_assertions.sv */
// Concurrent assertions on the D+/D- pins, pkt_end_o and buffer credits
// Bound into the transmit top level
`timescale 1ns/1ns
`default_nettype none

module usb_tx_assertions #(
  parameter int Credits = usb_tx_pkg::DefCredits
) (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic                             cfg_pinflip_i,
  input logic                             usb_oe_i,
  input logic                             usb_dp_i,
  input logic                             usb_dn_i,
  input logic                             pkt_end_i,
  input logic                             valid_i,
  input logic [$clog2(Credits + 1)-1:0]   cred_i,
  input logic [$clog2(Credits + 1)-1:0]   skid_cnt_i
);

  // Released bus shows J for the flip setting of the previous cycle
  idle_is_j: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !usb_oe_i |-> {usb_dp_i, usb_dn_i} == ($past(cfg_pinflip_i) ? 2'b01 : 2'b10))
    else $error("pins not at J while bus released");

  no_se1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(usb_dp_i && usb_dn_i))
    else $error("D+ and D- both high");

  end_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pkt_end_i |=> !pkt_end_i)
    else $error("pkt_end_o longer than one cycle");

  credit_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    int'(cred_i) <= Credits)
    else $error("credit count above limit");

  // Each credit stands for a free slot in the serializer skid store
  send_with_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> int'(skid_cnt_i) < Credits)
    else $error("byte sent without a free skid slot");

endmodule

bind usb_tx_top usb_tx_assertions #(
  .Credits (Credits)
) u_assertions (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .cfg_pinflip_i (cfg_pinflip_i),
  .usb_oe_i      (usb_oe_o),
  .usb_dp_i      (usb_dp_o),
  .usb_dn_i      (usb_dn_o),
  .pkt_end_i     (pkt_end_o),
  .valid_i       (byte_if.valid),
  .cred_i        (u_buffer.cred_q),
  .skid_cnt_i    (u_serializer.sk_cnt_q)
);

`default_nettype wire

/* bench/usb_tx_clkgen.sv */
// Testbench clock of period 40 ns and active-low reset held for 16 cycles
`timescale 1ns/1ns
`default_nettype none

module usb_tx_clkgen #(
  parameter int PeriodNs    = 40,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release shortly after a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #5;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/usb_tx_stim.txt */
# pkt mode flip pid nbytes crc16 payload...   (all hex)
# mode 0 loads and sends all waiting packets, mode 1 only loads
pkt 0 0 2 0 0000
pkt 0 0 a 0 0000
pkt 0 0 3 9 4b37 31 32 33 34 35 36 37 38 39
pkt 0 0 b 1 40bf 00
# all-ones payload forces bit stuffing
pkt 0 0 3 2 0000 ff ff
pkt 0 1 b 2 0000 ff ff
pkt 0 1 2 0 0000
# two packets queued to fill the buffer
pkt 1 0 3 9 4b37 31 32 33 34 35 36 37 38 39
pkt 0 0 b 9 4b37 31 32 33 34 35 36 37 38 39

/* bench/usb_tx_tb.sv */
// Testbench for the USB full-speed transmit path
// Reads packets from the stim file, decodes D+/D- and checks bytes, EOP and flow control
`timescale 1ns/1ns
`default_nettype none

module usb_tx_tb;

  localparam int FifoDepth = usb_tx_pkg::DefFifoDepth;
  localparam int Credits   = usb_tx_pkg::DefCredits;
  localparam int BitDiv    = usb_tx_pkg::BitDiv;

  // Line states as {D+, D-} after undoing the pin flip
  localparam logic [1:0] LvlJ   = 2'b10;
  localparam logic [1:0] LvlK   = 2'b01;
  localparam logic [1:0] LvlSe0 = 2'b00;

  logic             clk_i, rst_ni;
  logic             link_reset_i, cfg_pinflip_i;
  logic             wr_valid_i, wr_last_i, wr_ready_o;
  logic [7:0]       wr_data_i;
  logic             pkt_start_i, pkt_end_o;
  usb_tx_pkg::pid_t pid_i;
  logic             usb_oe_o, usb_dp_o, usb_dn_o;

  int         rec_mode[$], rec_flip[$], rec_pid[$], rec_n[$], rec_crc[$], rec_first[$];
  logic [7:0] pay_q[$];
  int         limit_cycles = 48;
  int         cycle_cnt = 0;
  int         end_cnt = 0;
  int         err_cnt = 0;
  int         wait_n, ones;
  logic [1:0] prev_lvl;

  usb_tx_clkgen u_clkgen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  usb_tx_top #(
    .FifoDepth (FifoDepth),
    .Credits   (Credits)
  ) uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .link_reset_i  (link_reset_i),
    .cfg_pinflip_i (cfg_pinflip_i),
    .wr_valid_i    (wr_valid_i),
    .wr_data_i     (wr_data_i),
    .wr_last_i     (wr_last_i),
    .wr_ready_o    (wr_ready_o),
    .pkt_start_i   (pkt_start_i),
    .pid_i         (pid_i),
    .pkt_end_o     (pkt_end_o),
    .usb_oe_o      (usb_oe_o),
    .usb_dp_o      (usb_dp_o),
    .usb_dn_o      (usb_dn_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Error handling, timeout and end-of-packet counter
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check(input logic [31:0] exp_v, input logic [31:0] act_v,
                       input string what);
    if (exp_v !== act_v) begin
      err_cnt++;
      stop_run($sformatf("FAIL %0t ns: %s expected %0h got %0h",
                         $time, what, exp_v, act_v));
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > limit_cycles) begin
      stop_run($sformatf("Timeout: run did not finish within %0d cycles", limit_cycles));
    end
  end

  always @(posedge clk_i) begin
    if (pkt_end_o) begin
      end_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file and payload writer
  ////////////////////////////////////////////////////////////////////////////

  task automatic read_stim();
    int          fd;
    int          code;
    string       tok;
    string       rest;
    logic [31:0] mode, flip, pid, n, crc, v;
    fd = $fopen("bench/usb_tx_stim.txt", "r");
    if (fd == 0) begin
      stop_run("Cannot open the stimulus file bench/usb_tx_stim.txt");
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok[0] == "#") begin
        code = $fgets(rest, fd);
      end else if (tok == "pkt") begin
        code = $fscanf(fd, "%h %h %h %h %h", mode, flip, pid, n, crc);
        if (code != 5) begin
          stop_run("Malformed packet record in the stimulus file");
        end
        rec_mode.push_back(int'(mode));
        rec_flip.push_back(int'(flip));
        rec_pid.push_back(int'(pid));
        rec_n.push_back(int'(n));
        rec_crc.push_back(int'(crc));
        rec_first.push_back(pay_q.size());
        for (int i = 0; i < int'(n); i++) begin
          code = $fscanf(fd, "%h", v);
          if (code != 1) begin
            stop_run("Payload byte missing in the stimulus file");
          end
          pay_q.push_back(v[7:0]);
        end
        // Budget in bit times per packet
        limit_cycles += (60 + 40 * int'(n)) * BitDiv;
      end else begin
        stop_run("Unknown record in the stimulus file");
      end
    end
    $fclose(fd);
  endtask

  task automatic load_payload(input int first, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      #5;
      check(32'(1), 32'(wr_ready_o), "wr_ready_o before write");
      wr_valid_i = 1'b1;
      wr_data_i  = pay_q[first + i];
      wr_last_i  = (i == n - 1);
    end
    @(posedge clk_i);
    #5;
    wr_valid_i = 1'b0;
    wr_last_i  = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Line decoder
  ////////////////////////////////////////////////////////////////////////////

  // Samples the middle of the next bit time
  task automatic next_level(output logic [1:0] lvl);
    repeat (wait_n) @(negedge clk_i);
    wait_n = BitDiv;
    lvl = cfg_pinflip_i ? {usb_dn_o, usb_dp_o} : {usb_dp_o, usb_dn_o};
  endtask

  // NRZI: no change is a 1, a change is a 0
  task automatic get_bit(output logic b);
    logic [1:0] lvl;
    next_level(lvl);
    check(32'(1), 32'(lvl == LvlJ || lvl == LvlK), "J or K state inside packet");
    b = (lvl == prev_lvl);
    prev_lvl = lvl;
  endtask

  task automatic get_data_bit(output logic b);
    logic sb;
    if (ones == 6) begin
      get_bit(sb);
      check(32'(0), 32'(sb), "stuffed bit after six ones");
      ones = 0;
    end
    get_bit(b);
    ones = b ? ones + 1 : 0;
  endtask

  task automatic send_packet(input int pid, input int first, input int n, input int crc);
    logic [3:0]  p;
    logic [15:0] c;
    logic [7:0]  exp_q[$];
    logic [7:0]  got;
    logic        b;
    logic [1:0]  lvl;
    int          e0;
    p = 4'(pid);
    c = 16'(crc);
    exp_q.push_back(8'h80);
    exp_q.push_back({~p, p});
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(pay_q[first + i]);
    end
    // Data PIDs carry the CRC inverted, low byte first
    if (p[1:0] == 2'b11) begin
      exp_q.push_back(~c[7:0]);
      exp_q.push_back(~c[15:8]);
    end
    e0 = end_cnt;
    @(posedge clk_i);
    #5;
    pid_i       = p;
    pkt_start_i = 1'b1;
    @(posedge clk_i);
    #5;
    pkt_start_i = 1'b0;
    while (!usb_oe_o) @(negedge clk_i);
    wait_n   = BitDiv / 2;
    prev_lvl = LvlJ;
    ones     = 0;
    foreach (exp_q[k]) begin
      got = '0;
      for (int i = 0; i < 8; i++) begin
        get_data_bit(b);
        got[i] = b;
      end
      check(32'(exp_q[k]), 32'(got), $sformatf("byte %0d of packet", k));
    end
    if (ones == 6) begin
      get_bit(b);
      check(32'(0), 32'(b), "stuffed bit before EOP");
    end
    next_level(lvl);
    check(32'(LvlSe0), 32'(lvl), "first EOP bit");
    next_level(lvl);
    check(32'(LvlSe0), 32'(lvl), "second EOP bit");
    next_level(lvl);
    check(32'(LvlJ), 32'(lvl), "closing J of EOP");
    while (end_cnt == e0) @(negedge clk_i);
    repeat (BitDiv) @(negedge clk_i);
    check(32'(e0 + 1), 32'(end_cnt), "pkt_end_o pulse count");
    check(32'(0), 32'(usb_oe_o), "usb_oe_o after packet");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int         pend_rec;
    int         pend_bytes;
    logic [1:0] idle_exp;
    link_reset_i  = 1'b0;
    cfg_pinflip_i = 1'b0;
    wr_valid_i    = 1'b0;
    wr_data_i     = '0;
    wr_last_i     = 1'b0;
    pkt_start_i   = 1'b0;
    pid_i         = '0;
    read_stim();
    @(posedge rst_ni);
    repeat (2) @(posedge clk_i);
    #5;
    check(32'(0), 32'(usb_oe_o), "usb_oe_o after reset");
    check(32'(1), 32'(wr_ready_o), "wr_ready_o after reset");
    check(32'(LvlJ), 32'({usb_dp_o, usb_dn_o}), "idle pins after reset");
    pend_rec   = 0;
    pend_bytes = 0;
    foreach (rec_mode[r]) begin
      @(posedge clk_i);
      #5;
      if (cfg_pinflip_i !== 1'(rec_flip[r])) begin
        cfg_pinflip_i = 1'(rec_flip[r]);
        repeat (2) @(posedge clk_i);
        #5;
      end
      idle_exp = cfg_pinflip_i ? 2'b01 : 2'b10;
      check(32'(0), 32'(usb_oe_o), "usb_oe_o before packet");
      check(32'(idle_exp), 32'({usb_dp_o, usb_dn_o}), "idle pins before packet");
      load_payload(rec_first[r], rec_n[r]);
      pend_bytes += rec_n[r];
      if (rec_mode[r] == 0) begin
        // Buffer and skid store together hold FifoDepth + Credits bytes
        repeat (4) @(posedge clk_i);
        #5;
        check(32'(pend_bytes < FifoDepth + Credits), 32'(wr_ready_o),
              "wr_ready_o after load");
        for (int q = pend_rec; q <= r; q++) begin
          send_packet(rec_pid[q], rec_first[q], rec_n[q], rec_crc[q]);
          pend_bytes -= rec_n[q];
          check(32'(pend_bytes < FifoDepth + Credits), 32'(wr_ready_o),
                "wr_ready_o after packet");
        end
        pend_rec = r + 1;
      end
    end
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/usb_tx_byte_buffer.sv */
// Payload FIFO of data and last pairs
// Forwards the head entry while it holds credits from the serializer
`timescale 1ns/1ns
`default_nettype none

module usb_tx_byte_buffer #(
  parameter int FifoDepth = usb_tx_pkg::DefFifoDepth,
  parameter int Credits   = usb_tx_pkg::DefCredits
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              link_reset_i,
  input  logic              wr_valid_i,
  input  logic [7:0]        wr_data_i,
  input  logic              wr_last_i,
  output logic              wr_ready_o,
  usb_tx_byte_if.sender     byte_o
);

  localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntW = $clog2(FifoDepth + 1);
  localparam int CrW  = $clog2(Credits + 1);

  logic [8:0]      mem [FifoDepth];
  logic [PtrW-1:0] wr_q, rd_q;
  logic [CntW-1:0] cnt_q;
  logic [CrW-1:0]  cred_q;
  logic            send;

  // One byte per cycle while both an entry and a credit are there
  assign send       = (cnt_q != '0) && (cred_q != '0);
  assign wr_ready_o = (cnt_q != CntW'(FifoDepth));

  assign byte_o.valid = send;
  assign byte_o.data  = mem[rd_q][7:0];
  assign byte_o.last  = mem[rd_q][8];

  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      mem[wr_q] <= {wr_last_i, wr_data_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_q   <= '0;
      rd_q   <= '0;
      cnt_q  <= '0;
      cred_q <= CrW'(Credits);
    end else if (link_reset_i) begin
      wr_q   <= '0;
      rd_q   <= '0;
      cnt_q  <= '0;
      cred_q <= CrW'(Credits);
    end else begin
      if (wr_valid_i) begin
        wr_q <= (wr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_q + 1'b1;
      end
      if (send) begin
        rd_q <= (rd_q == PtrW'(FifoDepth - 1)) ? '0 : rd_q + 1'b1;
      end
      cnt_q  <= cnt_q + CntW'(wr_valid_i) - CntW'(send);
      cred_q <= cred_q + CrW'(byte_o.credit) - CrW'(send);
    end
  end

endmodule

`default_nettype wire

/* hdl/usb_tx_byte_if.sv */
// Credit-based byte channel from the payload buffer to the serializer
`timescale 1ns/1ns
`default_nettype none

interface usb_tx_byte_if;

  logic       valid;
  logic [7:0] data;
  // Final payload byte of the packet
  logic       last;
  // One pulse returns one credit
  logic       credit;

  modport sender (output valid, data, last, input credit);
  modport receiver (input valid, data, last, output credit);

endinterface

`default_nettype wire

/* hdl/usb_tx_line_driver.sv */
// Line driver: NRZI coding, EOP shaping, pin flip
// and registered D+/D- outputs
`timescale 1ns/1ns
`default_nettype none

module usb_tx_line_driver (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          link_reset_i,
  input  logic          cfg_pinflip_i,
  usb_tx_line_if.sink   line_i,
  output logic          usb_oe_o,
  output logic          usb_dp_o,
  output logic          usb_dn_o,
  output logic          pkt_end_o
);

  logic       oe_q, oe_d;
  logic       usb_d_q, usb_d_d;
  logic       se0_q, se0_d;
  logic [2:0] eop_q, eop_d;
  logic       eop_end_q, eop_end_d;
  logic [1:0] line_s, pin_s, j_pins;

  ////////////////////////////////////////////////////////////////////////////
  // NRZI and EOP stage
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    oe_d      = oe_q;
    usb_d_d   = usb_d_q;
    se0_d     = se0_q;
    eop_d     = eop_q;
    eop_end_d = eop_end_q;
    if (line_i.start) begin
      // Start from J so the first SYNC bit becomes K
      usb_d_d = 1'b1;
      eop_d   = 3'b100;
    end else if (line_i.strobe) begin
      oe_d      = line_i.oe;
      eop_end_d = 1'b0;
      if (line_i.se0) begin
        eop_d = eop_q >> 1;
        if (eop_q[0]) begin
          usb_d_d   = 1'b1;
          se0_d     = 1'b0;
          eop_end_d = 1'b1;
        end else begin
          se0_d = 1'b1;
        end
      end else if (!line_i.tx_bit) begin
        usb_d_d = ~usb_d_q;
      end
      // Released bus sits at J
      if (!oe_d) begin
        usb_d_d = 1'b1;
        se0_d   = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {oe_q, se0_q, eop_end_q} <= '0;
      usb_d_q <= 1'b1;
      eop_q   <= '0;
    end else if (link_reset_i) begin
      {oe_q, se0_q, eop_end_q} <= '0;
      usb_d_q <= 1'b1;
      eop_q   <= '0;
    end else begin
      oe_q      <= oe_d;
      usb_d_q   <= usb_d_d;
      se0_q     <= se0_d;
      eop_q     <= eop_d;
      eop_end_q <= eop_end_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pin flip and output registers
  ////////////////////////////////////////////////////////////////////////////

  assign line_s = se0_q ? usb_tx_pkg::LineSe0 :
                  usb_d_q ? usb_tx_pkg::LineJ : usb_tx_pkg::LineK;
  assign pin_s  = cfg_pinflip_i ? {line_s[0], line_s[1]} : line_s;
  assign j_pins = cfg_pinflip_i ? {usb_tx_pkg::LineJ[0], usb_tx_pkg::LineJ[1]}
                                : usb_tx_pkg::LineJ;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      usb_oe_o             <= 1'b0;
      {usb_dp_o, usb_dn_o} <= usb_tx_pkg::LineJ;
      pkt_end_o            <= 1'b0;
    end else if (link_reset_i) begin
      usb_oe_o             <= 1'b0;
      {usb_dp_o, usb_dn_o} <= j_pins;
      pkt_end_o            <= 1'b0;
    end else begin
      usb_oe_o             <= oe_q;
      {usb_dp_o, usb_dn_o} <= pin_s;
      // Last cycle of the closing J bit
      pkt_end_o            <= line_i.strobe && eop_end_q;
    end
  end

endmodule

`default_nettype wire

/* hdl/usb_tx_line_if.sv */
// Serial bit stream from the serializer to the line driver
`timescale 1ns/1ns
`default_nettype none

interface usb_tx_line_if;

  // One cycle per bit time
  logic strobe;
  // Current bit after stuffing
  logic tx_bit;
  logic oe;
  logic se0;
  logic start;

  modport source (output strobe, tx_bit, oe, se0, start);
  modport sink (input strobe, tx_bit, oe, se0, start);

endinterface

`default_nettype wire

/* hdl/usb_tx_pkg.sv */
// Shared definitions for the USB full-speed transmit path
// PID and CRC16 constants, line-state codes and default sizes
`default_nettype none

package usb_tx_pkg;

  typedef logic [3:0] pid_t;

  // Data PIDs have both low bits set
  localparam pid_t PidData0 = 4'b0011;
  localparam pid_t PidData1 = 4'b1011;
  localparam pid_t PidAck   = 4'b0010;
  localparam pid_t PidNak   = 4'b1010;

  // KJKJKJKK on the wire, sent LSB first
  localparam logic [7:0]  SyncByte  = 8'b1000_0000;
  localparam logic [15:0] Crc16Init = 16'hFFFF;
  localparam logic [15:0] Crc16Poly = 16'h8005;

  // Line states as {dp, dn}
  localparam logic [1:0] LineJ   = 2'b10;
  localparam logic [1:0] LineK   = 2'b01;
  localparam logic [1:0] LineSe0 = 2'b00;

  localparam int BitDiv       = 4;
  localparam int DefFifoDepth = 16;
  localparam int DefCredits   = 2;

endpackage

`default_nettype wire

/* hdl/usb_tx_serializer.sv */
// Packet serializer: bit strobe, framing FSM, skid store,
// bit stuffing and CRC16 over the payload
`timescale 1ns/1ns
`default_nettype none

module usb_tx_serializer #(
  parameter int Credits = usb_tx_pkg::DefCredits
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              link_reset_i,
  input  logic              pkt_start_i,
  input  usb_tx_pkg::pid_t  pid_i,
  usb_tx_byte_if.receiver   byte_i,
  usb_tx_line_if.source     line_o
);

  localparam int DivW    = $clog2(usb_tx_pkg::BitDiv);
  localparam int SkPtrW  = (Credits > 1) ? $clog2(Credits) : 1;
  localparam int SkCntW  = $clog2(Credits + 1);

  typedef enum logic [2:0] {Idle, Sync, Pid, Data, Crc0, Crc1, Eop} state_e;

  function automatic logic [7:0] rev8(input logic [7:0] v);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i] = v[7-i];
    end
    return r;
  endfunction

  logic [DivW-1:0]   div_q;
  logic              bit_stb, stuff, byte_end, pop;
  logic [8:0]        sk_mem [Credits];
  logic [SkPtrW-1:0] sk_wr_q, sk_rd_q;
  logic [SkCntW-1:0] sk_cnt_q;
  state_e            state_q, state_d;
  usb_tx_pkg::pid_t  pid_q;
  logic [7:0]        data_sr_q, data_d, oe_sr_q, oe_d, se0_sr_q, se0_d;
  logic              pay_q, pay_d;
  logic [2:0]        bit_cnt_q, ones_q, ones_d;
  logic [15:0]       crc_q, crc_step, crc_upd;
  logic              credit_q, strobe_q, start_q, bit_q, oe_q, se0_q;

  ////////////////////////////////////////////////////////////////////////////
  // Bit timing and skid store
  ////////////////////////////////////////////////////////////////////////////

  assign bit_stb = (div_q == DivW'(usb_tx_pkg::BitDiv - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_q <= '0;
    end else if (link_reset_i || bit_stb) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_i.valid) begin
      sk_mem[sk_wr_q] <= {byte_i.last, byte_i.data};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sk_wr_q  <= '0;
      sk_rd_q  <= '0;
      sk_cnt_q <= '0;
      credit_q <= 1'b0;
    end else if (link_reset_i) begin
      sk_wr_q  <= '0;
      sk_rd_q  <= '0;
      sk_cnt_q <= '0;
      credit_q <= 1'b0;
    end else begin
      if (byte_i.valid) begin
        sk_wr_q <= (sk_wr_q == SkPtrW'(Credits - 1)) ? '0 : sk_wr_q + 1'b1;
      end
      if (pop) begin
        sk_rd_q <= (sk_rd_q == SkPtrW'(Credits - 1)) ? '0 : sk_rd_q + 1'b1;
      end
      sk_cnt_q <= sk_cnt_q + SkCntW'(byte_i.valid) - SkCntW'(pop);
      // Every byte taken out hands one credit back
      credit_q <= pop;
    end
  end

  assign byte_i.credit = credit_q;

  ////////////////////////////////////////////////////////////////////////////
  // Stuffing, CRC and framing
  ////////////////////////////////////////////////////////////////////////////

  // After six ones a 0 goes out and the shift registers hold
  assign stuff    = (ones_q == 3'd6);
  assign byte_end = bit_stb && !stuff && (bit_cnt_q == 3'd7) && !pkt_start_i;

  always_comb begin
    if (stuff) begin
      ones_d = '0;
    end else if (oe_sr_q[0] && !se0_sr_q[0] && data_sr_q[0]) begin
      ones_d = ones_q + 1'b1;
    end else begin
      ones_d = '0;
    end
  end

  assign crc_step = {crc_q[14:0], 1'b0} ^
                    (usb_tx_pkg::Crc16Poly & {16{data_sr_q[0] ^ crc_q[15]}});
  assign crc_upd  = (bit_stb && !stuff && pay_q) ? crc_step : crc_q;

  always_comb begin
    state_d = state_q;
    pay_d   = pay_q;
    pop     = 1'b0;
    data_d  = data_sr_q;
    oe_d    = oe_sr_q;
    se0_d   = se0_sr_q;
    if (bit_stb && !stuff) begin
      data_d = {1'b0, data_sr_q[7:1]};
      oe_d   = {1'b0, oe_sr_q[7:1]};
      se0_d  = {1'b0, se0_sr_q[7:1]};
    end
    // Next field is loaded right as the eighth bit leaves
    if (byte_end) begin
      pay_d = 1'b0;
      oe_d  = 8'hFF;
      se0_d = 8'h00;
      unique case (state_q)
        Idle: begin
          oe_d = 8'h00;
        end
        Sync: begin
          data_d  = usb_tx_pkg::SyncByte;
          state_d = Pid;
        end
        Pid: begin
          data_d  = {~pid_q, pid_q};
          state_d = (pid_q[1:0] == 2'b11) ? Data : Eop;
        end
        Data: begin
          if (sk_cnt_q != '0) begin
            pop     = 1'b1;
            pay_d   = 1'b1;
            data_d  = sk_mem[sk_rd_q][7:0];
            state_d = sk_mem[sk_rd_q][8] ? Crc0 : Data;
          end else begin
            // Missing byte ends the payload early
            data_d  = ~rev8(crc_upd[15:8]);
            state_d = Crc1;
          end
        end
        Crc0: begin
          data_d  = ~rev8(crc_upd[15:8]);
          state_d = Crc1;
        end
        Crc1: begin
          data_d  = ~rev8(crc_upd[7:0]);
          state_d = Eop;
        end
        Eop: begin
          data_d  = 8'h00;
          oe_d    = 8'h07;
          se0_d   = 8'h07;
          state_d = Idle;
        end
        default: state_d = Idle;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Idle;
      pid_q     <= '0;
      data_sr_q <= '0;
      oe_sr_q   <= '0;
      se0_sr_q  <= '0;
      pay_q     <= 1'b0;
      bit_cnt_q <= '0;
      ones_q    <= '0;
      crc_q     <= '0;
    end else if (link_reset_i) begin
      state_q   <= Idle;
      pid_q     <= '0;
      data_sr_q <= '0;
      oe_sr_q   <= '0;
      se0_sr_q  <= '0;
      pay_q     <= 1'b0;
      bit_cnt_q <= '0;
      ones_q    <= '0;
      crc_q     <= '0;
    end else if (pkt_start_i) begin
      // One idle bit goes out before the SYNC byte
      state_q   <= Sync;
      pid_q     <= pid_i;
      oe_sr_q   <= '0;
      se0_sr_q  <= '0;
      pay_q     <= 1'b0;
      bit_cnt_q <= 3'd7;
      ones_q    <= '0;
      crc_q     <= usb_tx_pkg::Crc16Init;
    end else begin
      state_q   <= state_d;
      data_sr_q <= data_d;
      oe_sr_q   <= oe_d;
      se0_sr_q  <= se0_d;
      pay_q     <= pay_d;
      crc_q     <= crc_upd;
      if (bit_stb) begin
        ones_q <= ones_d;
        if (!stuff) begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end
    end
  end

  // Registered line outputs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      {strobe_q, start_q, bit_q, oe_q, se0_q} <= '0;
    end else if (link_reset_i) begin
      {strobe_q, start_q, bit_q, oe_q, se0_q} <= '0;
    end else begin
      strobe_q <= bit_stb;
      start_q  <= pkt_start_i;
      if (bit_stb) begin
        bit_q <= stuff ? 1'b0 : data_sr_q[0];
        oe_q  <= stuff ? 1'b1 : oe_sr_q[0];
        se0_q <= stuff ? 1'b0 : se0_sr_q[0];
      end
    end
  end

  assign line_o.strobe = strobe_q;
  assign line_o.start  = start_q;
  assign line_o.tx_bit = bit_q;
  assign line_o.oe     = oe_q;
  assign line_o.se0    = se0_q;

endmodule

`default_nettype wire

/* hdl/usb_tx_top.sv */
// Top level of the USB full-speed transmit path
// Buffer, serializer and line driver joined by two interfaces
`timescale 1ns/1ns
`default_nettype none

module usb_tx_top #(
  parameter int FifoDepth = usb_tx_pkg::DefFifoDepth,
  parameter int Credits   = usb_tx_pkg::DefCredits
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              link_reset_i,
  input  logic              cfg_pinflip_i,
  input  logic              wr_valid_i,
  input  logic [7:0]        wr_data_i,
  input  logic              wr_last_i,
  output logic              wr_ready_o,
  input  logic              pkt_start_i,
  input  usb_tx_pkg::pid_t  pid_i,
  output logic              pkt_end_o,
  output logic              usb_oe_o,
  output logic              usb_dp_o,
  output logic              usb_dn_o
);

  usb_tx_byte_if byte_if ();
  usb_tx_line_if line_if ();

  usb_tx_byte_buffer #(
    .FifoDepth (FifoDepth),
    .Credits   (Credits)
  ) u_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .wr_valid_i   (wr_valid_i),
    .wr_data_i    (wr_data_i),
    .wr_last_i    (wr_last_i),
    .wr_ready_o   (wr_ready_o),
    .byte_o       (byte_if.sender)
  );

  usb_tx_serializer #(
    .Credits (Credits)
  ) u_serializer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .pkt_start_i  (pkt_start_i),
    .pid_i        (pid_i),
    .byte_i       (byte_if.receiver),
    .line_o       (line_if.source)
  );

  usb_tx_line_driver u_line (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .link_reset_i  (link_reset_i),
    .cfg_pinflip_i (cfg_pinflip_i),
    .line_i        (line_if.sink),
    .usb_oe_o      (usb_oe_o),
    .usb_dp_o      (usb_dp_o),
    .usb_dn_o      (usb_dn_o),
    .pkt_end_o     (pkt_end_o)
  );

endmodule

`default_nettype wire

/* project.f */
hdl/usb_tx_pkg.sv
hdl/usb_tx_byte_if.sv
hdl/usb_tx_line_if.sv
hdl/usb_tx_byte_buffer.sv
hdl/usb_tx_serializer.sv
hdl/usb_tx_line_driver.sv
hdl/usb_tx_top.sv
bench/usb_tx_clkgen.sv
bench/usb_tx_assertions.sv
bench/usb_tx_tb.sv
